//--- Makefile
# Verilator build and run of the I2S serializer testbench
# pass is decided by the pass message in sim.log

TOP := i2s_audio_out_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) \
		-Mdir obj_dir -f i2s_audio.f
	./obj_dir/V$(TOP) > sim.log 2>&1; cat sim.log
	grep -q "ALL CHECKS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

//--- dv/i2s_audio_out_tb.sv
/*
  self-checking testbench for the I2S serializer, 40 random frames
  samples change only while lrck is low, long before the next reload
  dac is checked once per slot, in the last mclk of the sclk high phase
*/

`timescale 1ns/10ps
`default_nettype none

module i2s_audio_out_tb import i2s_pkg::*; ();

    //////////////////////////////
    // run limits
    //////////////////////////////

    localparam int seed_lp = 11277;
    localparam int frames_lp = 40;
    // mclk cycles in one lrck half
    localparam int half_cyc_lp = slots_per_half_lp * mclk_per_bit_lp;
    // 40 x 256 cycles plus the first half, reset and some slack
    localparam int cycle_limit_lp = 12000;

    //////////////////////////////
    // DUT and clock
    //////////////////////////////

    logic         audgen_mclk = 1'b0;
    logic         rst_n = 1'b0;
    audio_frame_u sample = '0;
    logic         sclk;
    logic         lrck;
    logic         dac;

    // 100 ns period
    always #50 audgen_mclk = ~audgen_mclk;

    i2s_audio_out u_i2s_audio_out (
        .audgen_mclk (audgen_mclk),
        .rst_n       (rst_n),
        .sample      (sample),
        .sclk        (sclk),
        .lrck        (lrck),
        .dac         (dac)
    );

    //////////////////////////////
    // reference model state
    //////////////////////////////

    logic                  in_reset_q = 1'b0;
    logic                  prev_sclk;
    logic                  prev_lrck;
    // set by the first lrck rise, before it dac is all zero
    logic                  frame_valid;
    // sclk rises since the last lrck edge, all ones before the first
    logic [5:0]            slot_cnt;
    // word the DUT reloaded for the current frame
    audio_frame_u          frame_word;
    // deserialized data bits of the current frame
    logic [frame_w_lp-1:0] rx_word;
    int                    rise_gap;
    int                    high_len;
    int                    lrck_gap;
    logic                  sclk_seen;
    logic                  lrck_seen;
    logic                  redrive_q;
    int                    frames_done;
    int                    dac_checks;
    int                    error_cnt = 0;
    int                    cycle_cnt = 0;

    logic       sclk_rise;
    logic       sclk_fall;
    logic       lrck_edge;
    logic       slot_sample;
    logic       data_slot;
    logic [3:0] bit_idx;
    logic       exp_left;
    logic       exp_right;
    logic       chk_idle;
    logic       chk_left;
    logic       chk_right;
    logic       chk_tail;

    assign sclk_rise = sclk && !prev_sclk;
    assign sclk_fall = !sclk && prev_sclk;
    assign lrck_edge = lrck != prev_lrck;
    // second mclk of sclk high, slot_cnt already moved
    assign slot_sample = sclk && prev_sclk;

    // slot 0 is the I2S delay slot, data sits in slots 1..16
    assign data_slot = (slot_cnt != 6'd0) && (slot_cnt <= 6'(chan_w_lp));
    // slot 1 carries bit 15, slot 16 carries bit 0
    assign bit_idx = 4'(chan_w_lp - int'(slot_cnt));
    assign exp_left = frame_word.chan.left[bit_idx];
    assign exp_right = frame_word.chan.right[bit_idx];

    assign chk_idle = slot_sample && !frame_valid;
    assign chk_left = slot_sample && frame_valid && lrck && data_slot;
    assign chk_right = slot_sample && frame_valid && !lrck && data_slot;
    // rest of the right half, and the delay slot before the left data
    assign chk_tail = slot_sample && frame_valid &&
                      ((!lrck && slot_cnt > 6'(chan_w_lp)) || (lrck && slot_cnt == 6'd0));

    always @(posedge audgen_mclk) begin
        in_reset_q <= !rst_n;
        if (!rst_n) begin
            prev_sclk   <= 1'b0;
            prev_lrck   <= 1'b0;
            frame_valid <= 1'b0;
            slot_cnt    <= '1;
            frame_word  <= '0;
            rx_word     <= '0;
            rise_gap    <= 0;
            high_len    <= 0;
            lrck_gap    <= 0;
            sclk_seen   <= 1'b0;
            lrck_seen   <= 1'b0;
            frames_done <= 0;
            dac_checks  <= 0;
        end else begin
            prev_sclk <= sclk;
            prev_lrck <= lrck;
            // sclk period and high time
            if (sclk_rise) begin
                rise_gap  <= 1;
                sclk_seen <= 1'b1;
            end else begin
                rise_gap <= rise_gap + 1;
            end
            high_len <= sclk ? high_len + 1 : 0;
            // slot position inside the lrck half
            if (lrck_edge) begin
                slot_cnt  <= '1;
                lrck_gap  <= 1;
                lrck_seen <= 1'b1;
            end else begin
                lrck_gap <= lrck_gap + 1;
                if (sclk_rise) begin
                    slot_cnt <= slot_cnt + 1'b1;
                end
            end
            // new frame, the DUT reloaded the word held since the last fall
            if (lrck_edge && lrck) begin
                frame_word  <= sample;
                frame_valid <= 1'b1;
                if (frame_valid) begin
                    frames_done <= frames_done + 1;
                end
            end
            // deserializer, left bits first
            if (chk_left || chk_right) begin
                rx_word <= {rx_word[frame_w_lp-2:0], dac};
            end
            if (chk_idle || chk_left || chk_right || chk_tail) begin
                dac_checks <= dac_checks + 1;
            end
        end
    end

    //////////////////////////////
    // stimulus
    //////////////////////////////

    always @(posedge audgen_mclk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    // new word right after lrck falls
    // some frames get a second word halfway, only that one should go out
    always @(posedge audgen_mclk) begin
        if (!rst_n) begin
            sample.word <= $urandom;
            redrive_q   <= 1'b0;
        end else if (lrck_edge && !lrck) begin
            sample.word <= $urandom;
            redrive_q   <= ($urandom % 2) == 32'd1;
        end else if (redrive_q && !lrck && lrck_gap == half_cyc_lp / 2) begin
            sample.word <= $urandom;
            redrive_q   <= 1'b0;
        end
    end

    initial begin
        logic timed_out;
        timed_out = 1'b0;
        void'($urandom(seed_lp));
        // reset for 5 rising edges
        repeat (5) @(posedge audgen_mclk);
        rst_n <= 1'b1;
        while (frames_done < frames_lp && cycle_cnt < cycle_limit_lp) begin
            @(posedge audgen_mclk);
        end
        if (frames_done < frames_lp) begin
            timed_out = 1'b1;
            $display("timeout: %0d cycles ran out with only %0d of %0d frames done",
                     cycle_cnt, frames_done, frames_lp);
        end
        @(posedge audgen_mclk);
        $display("%0d frames, %0d dac checks, %0d errors", frames_done, dac_checks, error_cnt);
        if (!timed_out && error_cnt == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    //////////////////////////////
    // checks
    //////////////////////////////

    // all outputs held low while in reset and on the release edge
    ap_reset_low: assert property (
        @(posedge audgen_mclk) in_reset_q |-> (!sclk && !lrck && !dac)
    ) else begin
        error_cnt++;
        $display("[ERROR] %0t: outputs not low during reset", $time);
    end

    ap_sclk_period: assert property (
        @(posedge audgen_mclk) disable iff (!rst_n)
        (sclk_rise && sclk_seen) |-> (rise_gap == mclk_per_bit_lp)
    ) else begin
        error_cnt++;
        $display("[ERROR] %0t: sclk period is %0d mclk", $time, $sampled(rise_gap));
    end

    ap_sclk_high: assert property (
        @(posedge audgen_mclk) disable iff (!rst_n)
        sclk_fall |-> (high_len == mclk_per_bit_lp / 2)
    ) else begin
        error_cnt++;
        $display("[ERROR] %0t: sclk high for %0d mclk", $time, $sampled(high_len));
    end

    // 32 sclk periods per half
    ap_lrck_half: assert property (
        @(posedge audgen_mclk) disable iff (!rst_n)
        (lrck_edge && lrck_seen) |-> (lrck_gap == half_cyc_lp)
    ) else begin
        error_cnt++;
        $display("[ERROR] %0t: lrck half lasted %0d mclk", $time, $sampled(lrck_gap));
    end

    ap_idle_zero: assert property (
        @(posedge audgen_mclk) disable iff (!rst_n)
        chk_idle |-> !dac
    ) else begin
        error_cnt++;
        $display("[ERROR] %0t: dac high before the first frame", $time);
    end

    ap_left_bits: assert property (
        @(posedge audgen_mclk) disable iff (!rst_n)
        chk_left |-> (dac == exp_left)
    ) else begin
        error_cnt++;
        $display("[ERROR] %0t: left bit %0d is %b, expected %b", $time,
                 $sampled(bit_idx), $sampled(dac), $sampled(exp_left));
    end

    ap_right_bits: assert property (
        @(posedge audgen_mclk) disable iff (!rst_n)
        chk_right |-> (dac == exp_right)
    ) else begin
        error_cnt++;
        $display("[ERROR] %0t: right bit %0d is %b, expected %b", $time,
                 $sampled(bit_idx), $sampled(dac), $sampled(exp_right));
    end

    ap_tail_zero: assert property (
        @(posedge audgen_mclk) disable iff (!rst_n)
        chk_tail |-> !dac
    ) else begin
        error_cnt++;
        $display("[ERROR] %0t: dac high in slot %0d after the right channel", $time,
                 $sampled(slot_cnt));
    end

    // whole frame from one sample, no mixed halves
    ap_frame_word: assert property (
        @(posedge audgen_mclk) disable iff (!rst_n)
        (lrck_edge && lrck && frame_valid) |-> (rx_word == frame_word.word)
    ) else begin
        error_cnt++;
        $display("[ERROR] %0t: frame carried %h, expected %h", $time,
                 $sampled(rx_word), $sampled(frame_word.word));
    end

endmodule

`default_nettype wire

//--- i2s_audio.f
src/i2s_pkg.sv
src/sample_sync.sv
src/i2s_frame_ctrl.sv
src/sample_shifter.sv
src/i2s_audio_out.sv
dv/i2s_audio_out_tb.sv

//--- src/i2s_audio_out.sv
/*
  I2S audio output, single clock domain on audgen_mclk
  sample is asynchronous, hold each value at least 4 mclk cycles
  no back-pressure, one word is taken per frame and the rest are lost
*/

`timescale 1ns/10ps
`default_nettype none

module i2s_audio_out import i2s_pkg::*; (
    input  logic         audgen_mclk,
    input  logic         rst_n,
    input  audio_frame_u sample,
    output logic         sclk,
    output logic         lrck,
    output logic         dac
);

    //////////////////////////////
    // internal nets
    //////////////////////////////

    // filtered word into the shifter
    audio_frame_u stable_sample;
    // per-slot strobes
    shift_ctrl_t  ctrl;

    //////////////////////////////
    // input side
    //////////////////////////////

    sample_sync u_sample_sync (
        .audgen_mclk   (audgen_mclk),
        .rst_n         (rst_n),
        .sample        (sample),
        .stable_sample (stable_sample)
    );

    //////////////////////////////
    // timing
    //////////////////////////////

    // sclk = mclk / 4, lrck = sclk / 64
    i2s_frame_ctrl u_i2s_frame_ctrl (
        .audgen_mclk (audgen_mclk),
        .rst_n       (rst_n),
        .ctrl        (ctrl),
        .sclk        (sclk),
        .lrck        (lrck)
    );

    //////////////////////////////
    // serial data
    //////////////////////////////

    sample_shifter u_sample_shifter (
        .audgen_mclk   (audgen_mclk),
        .rst_n         (rst_n),
        .ctrl          (ctrl),
        .stable_sample (stable_sample),
        .dac           (dac)
    );

endmodule

`default_nettype wire

//--- src/i2s_frame_ctrl.sv
/*
  frame sequencer, one sclk per 4 mclk, 64 bit slots per frame
  bit_en is the last mclk of the sclk high phase, so all shifter
  updates land on the sclk falling edge
  lrck is low out of reset, the first load comes at the end of slot 31
*/

`timescale 1ns/10ps
`default_nettype none

module i2s_frame_ctrl import i2s_pkg::*; (
    input  logic        audgen_mclk,
    input  logic        rst_n,
    output shift_ctrl_t ctrl,
    output logic        sclk,
    output logic        lrck
);

    //////////////////////////////
    // bit clock
    //////////////////////////////

    logic [phase_w_lp-1:0]   phase_q;
    logic [bit_cnt_w_lp-1:0] slot_q;
    logic                    lrck_q;

    logic bit_en;
    logic slot_last;
    logic data_slot;

    // free running mclk divider
    always_ff @(posedge audgen_mclk) begin
        if (!rst_n) begin
            phase_q <= '0;
        end else begin
            phase_q <= phase_q + 1'b1;
        end
    end

    // sclk low for phases 0,1 and high for 2,3
    assign sclk = phase_q[phase_w_lp-1];

    // last phase of the period, next edge is the sclk fall
    assign bit_en = (phase_q == phase_w_lp'(mclk_per_bit_lp - 1));

    //////////////////////////////
    // slot counter and word clock
    //////////////////////////////

    // final slot of an lrck half
    assign slot_last = (slot_q == bit_cnt_w_lp'(slots_per_half_lp - 1));

    // first 16 slots of a half carry channel data
    assign data_slot = (slot_q < bit_cnt_w_lp'(chan_w_lp));

    always_ff @(posedge audgen_mclk) begin
        if (!rst_n) begin
            slot_q <= '0;
            lrck_q <= 1'b0;
        end else if (bit_en) begin
            // wraps 31 -> 0 on its own
            slot_q <= slot_q + 1'b1;
            if (slot_last) begin
                lrck_q <= ~lrck_q;
            end
        end
    end

    assign lrck = lrck_q;

    //////////////////////////////
    // shifter strobes
    //////////////////////////////

    always_comb begin
        ctrl = '0;
        ctrl.bit_en = bit_en;
        // reload just as the left half starts, lrck still low here
        ctrl.load = bit_en && slot_last && !lrck_q;
        // slot 31 is never below 16, so this cannot meet load
        ctrl.shift = bit_en && data_slot;
    end

    //////////////////////////////
    // checks
    //////////////////////////////

    // exactly one bit_en per sclk period
    ap_bit_en_period: assert property (
        @(posedge audgen_mclk) disable iff (!rst_n)
        ctrl.bit_en |=> !ctrl.bit_en [*(mclk_per_bit_lp - 1)] ##1 ctrl.bit_en
    ) else $error("bit_en spacing is not %0d cycles", mclk_per_bit_lp);

    // word clock only moves after the last slot of a half
    ap_lrck_edge: assert property (
        @(posedge audgen_mclk) disable iff (!rst_n)
        !$stable(lrck) |-> $past(bit_en && slot_last)
    ) else $error("lrck moved outside slot 31");

    ap_load_shift_excl: assert property (
        @(posedge audgen_mclk) disable iff (!rst_n)
        !(ctrl.load && ctrl.shift)
    ) else $error("load and shift set together");

endmodule

`default_nettype wire

//--- src/i2s_pkg.sv
/*
  shared constants and types for the I2S serializer
  the frame layout is fixed at 2 x 16-bit channels, 64 bit slots per frame
  mclk_per_bit_lp must stay a power of two for the phase counter
*/

`default_nettype none

package i2s_pkg;

    //////////////////////////////
    // frame geometry
    //////////////////////////////

    // one channel sample
    localparam int chan_w_lp = 16;
    // left + right word
    localparam int frame_w_lp = 32;
    // mclk cycles per sclk period
    localparam int mclk_per_bit_lp = 4;
    // phase counter width, log2 of the divide ratio
    localparam int phase_w_lp = $clog2(mclk_per_bit_lp);
    // bit slots in one lrck half
    localparam int slots_per_half_lp = 32;
    // slot counter width
    localparam int bit_cnt_w_lp = 5;

    //////////////////////////////
    // types
    //////////////////////////////

    // sample word, raw for the datapath
    // split view for anything that looks at channels
    typedef union packed {
        logic [frame_w_lp-1:0] word;
        struct packed {
            logic [chan_w_lp-1:0] left;
            logic [chan_w_lp-1:0] right;
        } chan;
    } audio_frame_u;

    // per-cycle strobes from the sequencer to the shifter
    // load and shift only ever appear in a bit_en cycle
    typedef struct packed {
        logic bit_en;
        logic load;
        logic shift;
    } shift_ctrl_t;

endpackage

`default_nettype wire

//--- src/sample_shifter.sv
/*
  frame shift register, MSB first, zero fill from the bottom
  dac is registered and changes only on bit_en, i.e. on the sclk fall
  left bits go out in the 16 slots after lrck rises, right bits after it falls
*/

`timescale 1ns/10ps
`default_nettype none

module sample_shifter import i2s_pkg::*; (
    input  logic         audgen_mclk,
    input  logic         rst_n,
    input  shift_ctrl_t  ctrl,
    input  audio_frame_u stable_sample,
    output logic         dac
);

    //////////////////////////////
    // shift register
    //////////////////////////////

    logic [frame_w_lp-1:0] shift_q;
    logic                  dac_q;

    // next word into the register
    logic [frame_w_lp-1:0] shift_d;

    always_comb begin
        shift_d = shift_q;
        if (ctrl.load) begin
            // whole frame at once, left half on top
            shift_d = stable_sample.word;
        end else if (ctrl.shift) begin
            shift_d = {shift_q[frame_w_lp-2:0], 1'b0};
        end
    end

    always_ff @(posedge audgen_mclk) begin
        if (!rst_n) begin
            shift_q <= '0;
        end else if (ctrl.bit_en) begin
            shift_q <= shift_d;
        end
    end

    //////////////////////////////
    // serial output
    //////////////////////////////

    // msb as it was before this edge
    // so the bit loaded at slot 31 shows one slot later
    always_ff @(posedge audgen_mclk) begin
        if (!rst_n) begin
            dac_q <= 1'b0;
        end else if (ctrl.bit_en) begin
            dac_q <= shift_q[frame_w_lp-1];
        end
    end

    assign dac = dac_q;

    //////////////////////////////
    // checks
    //////////////////////////////

    // register strobes from the sequencer must sit on a bit slot
    ap_strobe_on_bit: assert property (
        @(posedge audgen_mclk) disable iff (!rst_n)
        (ctrl.load || ctrl.shift) |-> ctrl.bit_en
    ) else $error("load or shift outside a bit_en cycle");

endmodule

`default_nettype wire

//--- src/sample_sync.sv
/*
  sample is asynchronous and must be held for at least 4 mclk cycles
  a settled word reaches stable_sample four mclk edges after it settles
  a word caught mid-change never reaches the output
*/

`timescale 1ns/10ps
`default_nettype none

module sample_sync import i2s_pkg::*; (
    input  logic         audgen_mclk,
    input  logic         rst_n,
    input  audio_frame_u sample,
    output audio_frame_u stable_sample
);

    //////////////////////////////
    // synchronizer chain
    //////////////////////////////

    // first stage may go metastable
    audio_frame_u meta_q;
    // second and third stages, compared below
    audio_frame_u sync_q;
    audio_frame_u hold_q;
    // last accepted word
    audio_frame_u stable_q;

    logic agree;

    always_ff @(posedge audgen_mclk) begin
        if (!rst_n) begin
            meta_q <= '0;
            sync_q <= '0;
            hold_q <= '0;
        end else begin
            meta_q <= sample;
            sync_q <= meta_q;
            hold_q <= sync_q;
        end
    end

    //////////////////////////////
    // stability filter
    //////////////////////////////

    // two successive copies match, so the bus was not moving
    // when stage two was captured
    assign agree = (sync_q.word == hold_q.word);

    always_ff @(posedge audgen_mclk) begin
        if (!rst_n) begin
            stable_q <= '0;
        end else if (agree) begin
            stable_q <= hold_q;
        end
    end

    // mismatching copies leave the last good word in place
    assign stable_sample = stable_q;

endmodule

`default_nettype wire
